/* Makefile */
VERILATOR ?= verilator
TOP       ?= lcd_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wall -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f sources.f --top-module $(TOP) --Mdir $(BUILD_DIR)
	-$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* rtl/lcd_display_top.sv */
// ILI9341 display path: RGB888 strobes in, 16-bit 8080 write bus out.
// Defaults assume a 25 MHz clock; the panel bus then runs at half that.
`default_nettype none

module lcd_display_top #(
    parameter int RST_LOW_CLKS = 250,        // About 10 us
    parameter int DELAY_CLKS   = 3_000_000,  // About 120 ms
    parameter int FRAME_W      = 320,
    parameter int FRAME_H      = 240
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        pixel_valid,
    input  logic [23:0] pixel_rgb,
    output logic        ready,
    output logic        frame_end,
    output logic        tft_rst,
    output logic        tft_csx,
    output logic        tft_dcx,
    output logic        tft_wrx,
    output logic        tft_rdx,
    output logic [15:0] tft_data
);

    logic                           fmt_valid;
    lcd_pkg::pixel_t                fmt_pixel;
    logic [lcd_pkg::INIT_IDX_W-1:0] init_idx;
    lcd_pkg::bus_word_t             init_word;
    logic                           init_needs_delay;

    pixel_formatter #(
        .FRAME_W (FRAME_W),
        .FRAME_H (FRAME_H)
    ) i_formatter (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (pixel_valid),
        .in_rgb    (pixel_rgb),
        .out_valid (fmt_valid),
        .out_pixel (fmt_pixel)
    );

    lcd_driver #(
        .RST_LOW_CLKS (RST_LOW_CLKS),
        .DELAY_CLKS   (DELAY_CLKS)
    ) i_driver (
        .clk              (clk),
        .reset            (reset),
        .in_valid         (fmt_valid),
        .in_pixel         (fmt_pixel),
        .init_idx         (init_idx),
        .init_word        (init_word),
        .init_needs_delay (init_needs_delay),
        .ready            (ready),
        .frame_end        (frame_end),
        .tft_rst          (tft_rst),
        .tft_csx          (tft_csx),
        .tft_dcx          (tft_dcx),
        .tft_wrx          (tft_wrx),
        .tft_rdx          (tft_rdx),
        .tft_data         (tft_data)
    );

    lcd_init_rom i_init_rom (
        .idx         (init_idx),
        .word        (init_word),
        .needs_delay (init_needs_delay)
    );

endmodule

`default_nettype wire

/* rtl/lcd_driver.sv */
// ILI9341 8080 write-bus driver with two clocks per bus word and no back-pressure.
// Pixel strobes must be two or more cycles apart and only while ready is high.
`default_nettype none

module lcd_driver #(
    parameter int RST_LOW_CLKS = 250,
    parameter int DELAY_CLKS   = 3_000_000
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            in_valid,
    input  lcd_pkg::pixel_t                 in_pixel,
    output logic [lcd_pkg::INIT_IDX_W-1:0]  init_idx,
    input  lcd_pkg::bus_word_t              init_word,
    input  logic                            init_needs_delay,
    output logic                            ready,
    output logic                            frame_end,
    output logic                            tft_rst,
    output logic                            tft_csx,
    output logic                            tft_dcx,
    output logic                            tft_wrx,
    output logic                            tft_rdx,
    output logic [15:0]                     tft_data
);

    localparam int RST_W   = $clog2(RST_LOW_CLKS + 1);
    localparam int DELAY_W = $clog2(DELAY_CLKS + 1);
    localparam logic [RST_W-1:0]   RST_LAST   = RST_W'(RST_LOW_CLKS - 1);
    localparam logic [DELAY_W-1:0] DELAY_LAST = DELAY_W'(DELAY_CLKS - 1);

    lcd_pkg::drv_state_t state;
    lcd_pkg::drv_state_t state_next;

    logic [RST_W-1:0]   rst_cnt;
    logic [DELAY_W-1:0] delay_cnt;
    logic               rst_done;
    logic               delay_done;
    logic               in_wait;
    lcd_pkg::pixel_t    pix_reg;  // Pixel on the bus

    assign in_wait    = (state == lcd_pkg::st_rst_wait) || (state == lcd_pkg::st_init_wait);
    assign rst_done   = (rst_cnt == RST_LAST);
    assign delay_done = (delay_cnt == DELAY_LAST);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= lcd_pkg::st_rst_start;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            lcd_pkg::st_rst_start: state_next = lcd_pkg::st_rst_low;
            lcd_pkg::st_rst_low: begin
                if (rst_done) begin
                    state_next = lcd_pkg::st_rst_wait;
                end
            end
            lcd_pkg::st_rst_wait: begin
                if (delay_done) begin
                    state_next = lcd_pkg::st_init_write;
                end
            end
            lcd_pkg::st_init_write: state_next = lcd_pkg::st_init_busy;
            lcd_pkg::st_init_busy: begin
                if (init_needs_delay) begin
                    state_next = lcd_pkg::st_init_wait;
                end else if (init_idx == lcd_pkg::INIT_LAST) begin
                    state_next = lcd_pkg::st_idle;  // Table finished
                end else begin
                    state_next = lcd_pkg::st_init_write;
                end
            end
            lcd_pkg::st_init_wait: begin
                if (delay_done) begin
                    state_next = lcd_pkg::st_init_write;
                end
            end
            lcd_pkg::st_idle: begin
                if (in_valid) begin
                    state_next = lcd_pkg::st_write;
                end
            end
            lcd_pkg::st_write: state_next = lcd_pkg::st_write_busy;
            lcd_pkg::st_write_busy: begin
                // Back-to-back pixel keeps the bus busy
                state_next = in_valid ? lcd_pkg::st_write : lcd_pkg::st_idle;
            end
            default: state_next = lcd_pkg::st_rst_start;
        endcase
    end

    // Reset pulse length
    always_ff @(posedge clk) begin
        if (reset) begin
            rst_cnt <= '0;
        end else if (state == lcd_pkg::st_rst_low && !rst_done) begin
            rst_cnt <= rst_cnt + 1'b1;
        end else begin
            rst_cnt <= '0;
        end
    end

    // Shared by the post-reset wait and the table waits
    always_ff @(posedge clk) begin
        if (reset) begin
            delay_cnt <= '0;
        end else if (in_wait && !delay_done) begin
            delay_cnt <= delay_cnt + 1'b1;
        end else begin
            delay_cnt <= '0;
        end
    end

    // Table index advances after each word's high phase
    always_ff @(posedge clk) begin
        if (reset) begin
            init_idx <= '0;
        end else if (state == lcd_pkg::st_init_busy && init_idx != lcd_pkg::INIT_LAST) begin
            init_idx <= init_idx + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (state_next == lcd_pkg::st_write) begin
            pix_reg <= in_pixel;
        end
    end

    assign ready = (state == lcd_pkg::st_idle) || (state == lcd_pkg::st_write)
                   || (state == lcd_pkg::st_write_busy);
    assign frame_end = (state == lcd_pkg::st_write) && pix_reg.last;

    assign tft_rst  = (state != lcd_pkg::st_rst_low);  // Active low
    assign tft_csx  = lcd_pkg::CSX_ACTIVE;
    assign tft_rdx  = lcd_pkg::RDX_IDLE;
    assign tft_wrx  = !((state == lcd_pkg::st_write) || (state == lcd_pkg::st_init_write));
    assign tft_dcx  = ready ? lcd_pkg::DCX_DATA : init_word.dcx;
    assign tft_data = ready ? pix_reg.rgb565 : init_word.data;

endmodule

`default_nettype wire

/* rtl/lcd_init_rom.sv */
// ILI9341 power-up words for a fixed 320x240 window in RGB565 mode.
// Indices 0 and 49 (software reset, sleep out) need a long wait afterwards.
`default_nettype none

module lcd_init_rom (
    input  logic [lcd_pkg::INIT_IDX_W-1:0] idx,
    output lcd_pkg::bus_word_t              word,
    output logic                            needs_delay
);

    function automatic lcd_pkg::bus_word_t cmd_word(input lcd_pkg::cmd_t c);
        cmd_word = '{dcx: lcd_pkg::DCX_CMD, data: {8'h00, c}};
    endfunction

    function automatic lcd_pkg::bus_word_t prm_word(input logic [7:0] b);
        prm_word = '{dcx: lcd_pkg::DCX_DATA, data: {8'h00, b}};
    endfunction

    always_comb begin
        case (idx)
            6'd0:  word = cmd_word(lcd_pkg::cmd_swreset);
            6'd1:  word = cmd_word(lcd_pkg::cmd_display_off);
            6'd2:  word = cmd_word(lcd_pkg::cmd_pwr_ctrl_a);
            6'd3:  word = prm_word(8'h39);
            6'd4:  word = prm_word(8'h2C);
            6'd5:  word = prm_word(8'h00);
            6'd6:  word = prm_word(8'h34);  // Core supply 1.6 V
            6'd7:  word = prm_word(8'h02);  // DDVDH 5.6 V
            6'd8:  word = cmd_word(lcd_pkg::cmd_pwr_ctrl_b);
            6'd9:  word = prm_word(8'h00);
            6'd10: word = prm_word(8'hC1);
            6'd11: word = prm_word(8'h30);
            6'd12: word = cmd_word(lcd_pkg::cmd_drv_timing_a);
            6'd13: word = prm_word(8'h85);
            6'd14: word = prm_word(8'h00);
            6'd15: word = prm_word(8'h78);
            6'd16: word = cmd_word(lcd_pkg::cmd_drv_timing_b);
            6'd17: word = prm_word(8'h00);
            6'd18: word = prm_word(8'h00);
            6'd19: word = cmd_word(lcd_pkg::cmd_pwr_on_seq);
            6'd20: word = prm_word(8'h64);
            6'd21: word = prm_word(8'h03);
            6'd22: word = prm_word(8'h12);
            6'd23: word = prm_word(8'h81);
            6'd24: word = cmd_word(lcd_pkg::cmd_pump_ratio);
            6'd25: word = prm_word(8'h20);  // DDVDH = 2xVCI
            6'd26: word = cmd_word(lcd_pkg::cmd_pwr_ctrl1);
            6'd27: word = prm_word(8'h23);  // GVDD 4.60 V
            6'd28: word = cmd_word(lcd_pkg::cmd_pwr_ctrl2);
            6'd29: word = prm_word(8'h10);
            6'd30: word = cmd_word(lcd_pkg::cmd_vcom_ctrl1);
            6'd31: word = prm_word(8'h2B);
            6'd32: word = prm_word(8'h2B);
            6'd33: word = cmd_word(lcd_pkg::cmd_vcom_ctrl2);
            6'd34: word = prm_word(8'hC0);
            6'd35: word = cmd_word(lcd_pkg::cmd_madctl);
            6'd36: word = prm_word(8'h28);  // Row/column swap, BGR order
            6'd37: word = cmd_word(lcd_pkg::cmd_pixel_format);
            6'd38: word = prm_word(8'h55);  // 16 bits per pixel
            6'd39: word = cmd_word(lcd_pkg::cmd_frame_ctrl);
            6'd40: word = prm_word(8'h00);
            6'd41: word = prm_word(8'h1B);  // About 70 Hz refresh
            6'd42: word = cmd_word(lcd_pkg::cmd_disp_func);
            6'd43: word = prm_word(8'h08);
            6'd44: word = prm_word(8'h82);
            6'd45: word = prm_word(8'h27);
            6'd46: word = prm_word(8'h00);
            6'd47: word = cmd_word(lcd_pkg::cmd_entry_mode);
            6'd48: word = prm_word(8'h07);
            6'd49: word = cmd_word(lcd_pkg::cmd_sleep_out);
            6'd50: word = cmd_word(lcd_pkg::cmd_display_on);
            6'd51: word = cmd_word(lcd_pkg::cmd_col_addr);
            6'd52: word = prm_word(8'h00);  // First column 0
            6'd53: word = prm_word(8'h00);
            6'd54: word = prm_word(8'h01);  // Last column 319
            6'd55: word = prm_word(8'h3F);
            6'd56: word = cmd_word(lcd_pkg::cmd_page_addr);
            6'd57: word = prm_word(8'h00);  // First row 0
            6'd58: word = prm_word(8'h00);
            6'd59: word = prm_word(8'h00);  // Last row 239
            6'd60: word = prm_word(8'hEF);
            6'd61: word = cmd_word(lcd_pkg::cmd_mem_write);
            default: word = cmd_word(lcd_pkg::cmd_nop);
        endcase
    end

    // Panel is busy after software reset and sleep out
    assign needs_delay = (idx == 6'd0) || (idx == 6'd49);

endmodule

`default_nettype wire

/* rtl/lcd_pkg.sv */
// Shared types and constants for the ILI9341 write path.
// Write-only bus with chip select always active and the read strobe idle.
`default_nettype none

package lcd_pkg;

    // Power-up table size
    localparam int INIT_LEN   = 62;
    localparam int INIT_IDX_W = 6;
    localparam logic [INIT_IDX_W-1:0] INIT_LAST = INIT_IDX_W'(INIT_LEN - 1);

    // 8080 bus levels
    localparam logic DCX_CMD    = 1'b0;  // Command word
    localparam logic DCX_DATA   = 1'b1;  // Parameter or pixel word
    localparam logic CSX_ACTIVE = 1'b0;  // Active-low chip select
    localparam logic RDX_IDLE   = 1'b1;  // Read strobe never pulsed

    typedef struct packed {
        logic [15:0] rgb565;
        logic        last;  // Final pixel of the frame
    } pixel_t;

    typedef struct packed {
        logic        dcx;
        logic [15:0] data;
    } bus_word_t;

    typedef enum logic [3:0] {
        st_rst_start,
        st_rst_low,
        st_rst_wait,
        st_init_write,
        st_init_busy,
        st_init_wait,
        st_idle,
        st_write,
        st_write_busy
    } drv_state_t;

    // ILI9341 command opcodes used at power-up
    typedef enum logic [7:0] {
        cmd_nop          = 8'h00,
        cmd_swreset      = 8'h01,
        cmd_sleep_out    = 8'h11,
        cmd_display_off  = 8'h28,
        cmd_display_on   = 8'h29,
        cmd_col_addr     = 8'h2A,
        cmd_page_addr    = 8'h2B,
        cmd_mem_write    = 8'h2C,
        cmd_madctl       = 8'h36,
        cmd_pixel_format = 8'h3A,
        cmd_frame_ctrl   = 8'hB1,
        cmd_disp_func    = 8'hB6,
        cmd_entry_mode   = 8'hB7,
        cmd_pwr_ctrl1    = 8'hC0,
        cmd_pwr_ctrl2    = 8'hC1,
        cmd_vcom_ctrl1   = 8'hC5,
        cmd_vcom_ctrl2   = 8'hC7,
        cmd_pwr_ctrl_a   = 8'hCB,
        cmd_pwr_ctrl_b   = 8'hCF,
        cmd_drv_timing_a = 8'hE8,
        cmd_drv_timing_b = 8'hEA,
        cmd_pwr_on_seq   = 8'hED,
        cmd_pump_ratio   = 8'hF7
    } cmd_t;

endpackage

`default_nettype wire

/* rtl/pixel_formatter.sv */
// Packs RGB888 to RGB565 by truncation without dithering.
// Position counters assume the source sends whole frames in raster order.
`default_nettype none

module pixel_formatter #(
    parameter int FRAME_W = 320,
    parameter int FRAME_H = 240
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             in_valid,
    input  logic [23:0]      in_rgb,
    output logic             out_valid,
    output lcd_pkg::pixel_t  out_pixel
);

    localparam int COL_W = $clog2(FRAME_W + 1);
    localparam int ROW_W = $clog2(FRAME_H + 1);
    localparam logic [COL_W-1:0] COL_LAST = COL_W'(FRAME_W - 1);
    localparam logic [ROW_W-1:0] ROW_LAST = ROW_W'(FRAME_H - 1);

    logic [COL_W-1:0] col;
    logic [ROW_W-1:0] row;
    logic             col_end;
    logic             row_end;

    assign col_end = (col == COL_LAST);
    assign row_end = (row == ROW_LAST);

    // Raster position wrapping at the frame size
    always_ff @(posedge clk) begin
        if (reset) begin
            col <= '0;
            row <= '0;
        end else if (in_valid) begin
            if (col_end) begin
                col <= '0;
                row <= row_end ? '0 : row + 1'b1;
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // Keep the top bits of each channel
    always_ff @(posedge clk) begin
        if (in_valid) begin
            out_pixel.rgb565 <= {in_rgb[23:19], in_rgb[15:10], in_rgb[7:3]};
            out_pixel.last   <= col_end && row_end;
        end
    end

endmodule

`default_nettype wire

/* sources.f */
rtl/lcd_pkg.sv
rtl/lcd_init_rom.sv
rtl/pixel_formatter.sv
rtl/lcd_driver.sv
rtl/lcd_display_top.sv
testbench/lcd_checker.sv
testbench/lcd_tb.sv

/* testbench/lcd_checker.sv */
// Protocol assertions for the driver, attached with bind.
// Strobe rules assume the source obeys ready and the two-cycle spacing.
`default_nettype none

module lcd_checker (
    input logic                clk,
    input logic                reset,
    input logic                in_valid,
    input logic                ready,
    input lcd_pkg::drv_state_t state,
    input logic                tft_csx,
    input logic                tft_rdx,
    input logic                tft_wrx
);
    timeunit 1ns;
    timeprecision 100ps;

    // Early or tight strobes are lost without back-pressure
    strobe_allowed: assert property (@(posedge clk) disable iff (reset)
        in_valid |-> (ready && state != lcd_pkg::st_write))
        else $error("pixel strobe while the driver cannot take it");

    bus_idle_lines: assert property (@(posedge clk) disable iff (reset)
        (tft_csx == 1'b0) && (tft_rdx == 1'b1))
        else $error("chip select or read strobe left its fixed level");

    wrx_single_low: assert property (@(posedge clk) disable iff (reset)
        !tft_wrx |=> tft_wrx)
        else $error("write strobe low for two cycles in a row");

endmodule

bind lcd_driver lcd_checker i_checker (
    .clk      (clk),
    .reset    (reset),
    .in_valid (in_valid),
    .ready    (ready),
    .state    (state),
    .tft_csx  (tft_csx),
    .tft_rdx  (tft_rdx),
    .tft_wrx  (tft_wrx)
);

`default_nettype wire

/* testbench/lcd_tb.sv */
// Testbench for the ILI9341 write path with short reset, delays and an 8x4 frame.
// Bus words are sampled at the clock edge that ends each write-strobe low cycle.
`default_nettype none

module lcd_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int RST_LOW_CLKS = 3;
    localparam int DELAY_CLKS   = 5;
    localparam int FRAME_W      = 8;
    localparam int FRAME_H      = 4;
    localparam int FRAME_PIX    = FRAME_W * FRAME_H;
    localparam int TIMEOUT      = 2000;

    localparam logic [7:0] INIT_BYTES [0:61] = '{
        8'h01, 8'h28, 8'hCB, 8'h39, 8'h2C, 8'h00, 8'h34, 8'h02, 8'hCF, 8'h00,
        8'hC1, 8'h30, 8'hE8, 8'h85, 8'h00, 8'h78, 8'hEA, 8'h00, 8'h00, 8'hED,
        8'h64, 8'h03, 8'h12, 8'h81, 8'hF7, 8'h20, 8'hC0, 8'h23, 8'hC1, 8'h10,
        8'hC5, 8'h2B, 8'h2B, 8'hC7, 8'hC0, 8'h36, 8'h28, 8'h3A, 8'h55, 8'hB1,
        8'h00, 8'h1B, 8'hB6, 8'h08, 8'h82, 8'h27, 8'h00, 8'hB7, 8'h07, 8'h11,
        8'h29, 8'h2A, 8'h00, 8'h00, 8'h01, 8'h3F, 8'h2B, 8'h00, 8'h00, 8'h00,
        8'hEF, 8'h2C
    };

    typedef struct packed {
        logic        dcx;
        logic [15:0] data;
        logic        fe;
        logic        rdy;
        int          cyc;
    } bus_rec_t;

    typedef struct packed {
        logic        dcx;
        logic [15:0] data;
        logic        fe;
        int          idx;       // Table index or -1 for pixels
        int          want_cyc;  // -1 when timing is free
    } exp_rec_t;

    logic        clk;
    logic        reset;
    logic        pixel_valid;
    logic [23:0] pixel_rgb;
    logic        ready;
    logic        frame_end;
    logic        tft_rst;
    logic        tft_csx;
    logic        tft_dcx;
    logic        tft_wrx;
    logic        tft_rdx;
    logic [15:0] tft_data;

    bus_rec_t    cap_q[$];
    exp_rec_t    exp_q[$];
    int          init_cyc [0:61];
    int          cyc = 0;
    int          checks = 0;
    int          errors = 0;
    int          fe_count = 0;
    int          pix_count = 0;
    bit          discard = 0;
    logic [31:0] rng = 32'hae5f_6108;

    lcd_display_top #(
        .RST_LOW_CLKS (RST_LOW_CLKS),
        .DELAY_CLKS   (DELAY_CLKS),
        .FRAME_W      (FRAME_W),
        .FRAME_H      (FRAME_H)
    ) i_dut (
        .clk         (clk),
        .reset       (reset),
        .pixel_valid (pixel_valid),
        .pixel_rgb   (pixel_rgb),
        .ready       (ready),
        .frame_end   (frame_end),
        .tft_rst     (tft_rst),
        .tft_csx     (tft_csx),
        .tft_dcx     (tft_dcx),
        .tft_wrx     (tft_wrx),
        .tft_rdx     (tft_rdx),
        .tft_data    (tft_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Commands carry dcx low and parameters dcx high
    function automatic logic [16:0] init_word_ref(input int idx);
        logic is_cmd;
        is_cmd = idx inside {0, 1, 2, 8, 12, 16, 19, 24, 26, 28, 30, 33, 35, 37,
                             39, 42, 47, 49, 50, 51, 56, 61};
        return {!is_cmd, 8'h00, INIT_BYTES[idx]};
    endfunction

    function automatic logic [15:0] pack_ref(input logic [23:0] rgb);
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
        r = rgb[23:16];
        g = rgb[15:8];
        b = rgb[7:0];
        return {r[7:3], g[7:2], b[7:3]};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        checks++;
        assert (got === want) else begin
            $display("ERR %s got %h expected %h", name, got, want);
            errors++;
        end
    endtask

    task automatic expect_cond(input string what, input logic cond);
        checks++;
        assert (cond) else begin
            $display("%s", what);
            errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        checks++;
        errors++;
        $display("timeout: %s", what);
    endtask

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic end_test(input string name, input int start_err);
        $display("test %s: %s", name, (errors == start_err) ? "ok" : "FAILED");
    endtask

    // Word sampled at the edge closing the strobe low cycle
    always @(posedge clk) begin
        if (!reset && !tft_wrx) begin
            cap_q.push_back('{tft_dcx, tft_data, frame_end, ready, cyc});
        end
        if (!reset && frame_end) begin
            fe_count <= fe_count + 1;
        end
        cyc <= cyc + 1;
    end

    always @(posedge clk) begin
        bus_rec_t c;
        exp_rec_t e;
        while (cap_q.size() > 0) begin
            c = cap_q.pop_front();
            if (!discard) begin
                if (exp_q.size() == 0) begin
                    expect_cond("bus write seen with no word expected", 1'b0);
                end else begin
                    e = exp_q.pop_front();
                    check_value("tft_dcx", c.dcx, e.dcx);
                    check_value("tft_data", c.data, e.data);
                    check_value("frame_end", c.fe, e.fe);
                    if (e.idx >= 0) begin
                        check_value("ready", c.rdy, 1'b0);
                        init_cyc[e.idx] = c.cyc;
                    end
                    if (e.want_cyc >= 0) begin
                        check_value("write_cycle", c.cyc, e.want_cyc);
                    end
                end
            end
        end
    end

    task automatic wait_drain(input string what);
        int t;
        t = 0;
        while (exp_q.size() > 0 && t < TIMEOUT) begin
            step();
            t++;
        end
        if (t >= TIMEOUT) begin
            report_timeout(what);
        end
        step();
    endtask

    task automatic send_pixel(input logic [23:0] rgb, input int gap, input bit timed);
        pix_count++;
        exp_q.push_back('{1'b1, pack_ref(rgb), (pix_count % FRAME_PIX) == 0, -1,
                          timed ? cyc + 2 : -1});
        pixel_valid = 1'b1;
        pixel_rgb   = rgb;
        step();
        pixel_valid = 1'b0;
        repeat (gap - 1) step();
    endtask

    // Releases reset, then checks the reset pulse and the whole table
    task automatic power_up_test(input string name_rst, input string name_tbl);
        int          start_err;
        int          lows;
        int          t;
        logic [16:0] w;
        start_err = errors;
        for (int i = 0; i < 62; i++) begin
            w = init_word_ref(i);
            exp_q.push_back('{w[16], w[15:0], 1'b0, i, -1});
        end
        reset = 1'b0;
        check_value("tft_rst", tft_rst, 1'b1);
        step();
        lows = 0;
        t = 0;
        while (tft_rst == 1'b0 && t < 100) begin
            check_value("ready", ready, 1'b0);
            lows++;
            t++;
            step();
        end
        if (t >= 100) begin
            report_timeout("tft_rst never returned high");
        end
        check_value("tft_rst_low_cycles", lows, RST_LOW_CLKS);
        end_test(name_rst, start_err);
        start_err = errors;
        wait_drain("power-up table not fully written");
        expect_cond("wait after index 0 too short", init_cyc[1] - init_cyc[0] >= DELAY_CLKS + 2);
        expect_cond("wait after index 49 too short",
                    init_cyc[50] - init_cyc[49] >= DELAY_CLKS + 2);
        t = 0;
        while (!ready && t < 50) begin
            step();
            t++;
        end
        if (t >= 50) begin
            report_timeout("ready did not rise after the table");
        end
        end_test(name_tbl, start_err);
    endtask

    initial begin
        int start_err;
        reset       = 1'b1;
        pixel_valid = 1'b0;
        pixel_rgb   = '0;
        repeat (5) step();
        power_up_test("1 reset pulse", "2 power-up table");

        start_err = errors;
        for (int i = 0; i < 20; i++) begin
            rng = xorshift32(rng);
            send_pixel(rng[23:0], 2 + int'(rng[31:30]), 1'b0);
        end
        wait_drain("random pixels not written");
        end_test("3 random pixels", start_err);

        start_err = errors;
        for (int i = 0; i < 12; i++) begin
            rng = xorshift32(rng);
            send_pixel(rng[23:0], 2, 1'b1);
        end
        wait_drain("burst pixels not written");
        end_test("4 back-to-back burst", start_err);

        start_err = errors;
        check_value("frame_end_count", fe_count, 1);
        for (int i = 0; i < FRAME_PIX; i++) begin
            rng = xorshift32(rng);
            send_pixel(rng[23:0], 2, 1'b1);
        end
        wait_drain("second frame not written");
        check_value("frame_end_count", fe_count, 2);
        end_test("5 frame end", start_err);

        // Reset in the middle of a burst
        discard = 1'b1;
        for (int i = 0; i < 5; i++) begin
            send_pixel(24'h00FF_00 + 24'(i), 2, 1'b0);
        end
        reset = 1'b1;
        repeat (5) step();
        exp_q.delete();
        discard   = 1'b0;
        pix_count = 0;
        power_up_test("6a reset pulse again", "6b power-up table again");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
